// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // alu operations, branches use sub and only look at eq
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    // execute operand source
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,  // value read in decode
        FWD_MEM = 2'd1,  // result of the instruction in memory
        FWD_WB  = 2'd2   // result of the instruction in write-back
    } fwd_sel_t;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // abi registers read by ecall
    localparam reg_addr_t REG_A0 = 5'd10;
    localparam reg_addr_t REG_A7 = 5'd17;

    // a7 service number that shows a0 on the leds
    localparam word_t ECALL_PRINT = 32'd34;

endpackage

`default_nettype wire

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero, same-cycle write is passed straight through
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result,
    output logic            eq
);

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD: result = a + b;
            rv_pkg::ALU_SUB: result = a - b;
            rv_pkg::ALU_AND: result = a & b;
            rv_pkg::ALU_OR:  result = a | b;
            rv_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};  // signed compare
            default:         result = a + b;
        endcase
    end

    // for beq / bne
    assign eq = (a == b);

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  rv_pkg::word_t     instr,
    output rv_pkg::alu_op_t   alu_op,
    output logic              alu_src,
    output logic              mem_read,
    output logic              mem_write,
    output logic              reg_write,
    output logic              branch_eq,
    output logic              branch_ne,
    output logic              jal,
    output logic              jalr,
    output logic              ecall,
    output logic              uses_rs2,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];

    always_comb begin
        alu_op    = rv_pkg::ALU_ADD;
        alu_src   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch_eq = 1'b0;
        branch_ne = 1'b0;
        jal       = 1'b0;
        jalr      = 1'b0;
        ecall     = 1'b0;
        uses_rs2  = 1'b0;
        rs1       = instr[19:15];
        rs2       = instr[24:20];
        imm       = {{20{instr[31]}}, instr[31:20]};  // I type by default
        case (opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                reg_write = 1'b1;
                alu_src   = (opcode == rv_pkg::OPC_OP_IMM);
                uses_rs2  = (opcode == rv_pkg::OPC_OP);
                case (funct3)
                    3'b111:  alu_op = rv_pkg::ALU_AND;
                    3'b110:  alu_op = rv_pkg::ALU_OR;
                    3'b010:  alu_op = rv_pkg::ALU_SLT;
                    // funct7 bit 30 only means sub for register ops
                    default: alu_op = (uses_rs2 && instr[30]) ? rv_pkg::ALU_SUB
                                                              : rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                alu_src   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                uses_rs2  = 1'b1;  // store data
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_pkg::OPC_BRANCH: begin
                alu_op    = rv_pkg::ALU_SUB;
                uses_rs2  = 1'b1;
                branch_eq = (funct3 == 3'b000);
                branch_ne = (funct3 == 3'b001);
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_pkg::OPC_JAL: begin
                jal       = 1'b1;
                reg_write = 1'b1;
                rs1       = '0;  // field is immediate bits, avoid false stalls
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            rv_pkg::OPC_JALR: begin
                jalr      = 1'b1;
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::OPC_SYSTEM: begin
                ecall = (funct3 == 3'b000) && (instr[31:20] == 12'h000);
                if (ecall) begin
                    // service number and argument come from a7 and a0
                    rs1      = rv_pkg::REG_A7;
                    rs2      = rv_pkg::REG_A0;
                    uses_rs2 = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  rv_pkg::reg_addr_t id_rs1,
    input  rv_pkg::reg_addr_t id_rs2,
    input  logic              id_uses_rs2,
    input  rv_pkg::reg_addr_t ex_rs1,
    input  rv_pkg::reg_addr_t ex_rs2,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              ex_mem_read,
    input  logic              mem_reg_write,
    input  logic              wb_reg_write,
    output logic              load_use,
    output rv_pkg::fwd_sel_t  fwd_a,
    output rv_pkg::fwd_sel_t  fwd_b
);

    logic mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;

    // load in execute, its data is not ready for decode yet
    assign load_use = ex_mem_read && ex_rd != '0 &&
                      (ex_rd == id_rs1 || (id_uses_rs2 && ex_rd == id_rs2));

    assign mem_hit_a = mem_reg_write && mem_rd != '0 && mem_rd == ex_rs1;
    assign mem_hit_b = mem_reg_write && mem_rd != '0 && mem_rd == ex_rs2;
    assign wb_hit_a  = wb_reg_write && wb_rd != '0 && wb_rd == ex_rs1;
    assign wb_hit_b  = wb_reg_write && wb_rd != '0 && wb_rd == ex_rs2;

    // the younger result wins
    always_comb begin
        fwd_a = rv_pkg::FWD_REG;
        fwd_b = rv_pkg::FWD_REG;
        if (mem_hit_a) fwd_a = rv_pkg::FWD_MEM;
        else if (wb_hit_a) fwd_a = rv_pkg::FWD_WB;
        if (mem_hit_b) fwd_b = rv_pkg::FWD_MEM;
        else if (wb_hit_b) fwd_b = rv_pkg::FWD_WB;
    end

endmodule

`default_nettype wire

// ==== hw/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int DMEM_WORDS = 1024
) (
    input  logic          clk,
    input  logic          we,
    input  rv_pkg::word_t addr,   // byte address
    input  rv_pkg::word_t wdata,
    output rv_pkg::word_t rdata
);

    localparam int AW = $clog2(DMEM_WORDS);

    rv_pkg::word_t mem [DMEM_WORDS];
    logic [AW-1:0] word_idx;

    assign word_idx = addr[AW+1:2];  // drop the byte offset

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_idx] <= wdata;
        end
    end

    assign rdata = mem[word_idx];

endmodule

`default_nettype wire

// ==== hw/riscv_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_cpu #(
    parameter int IMEM_ADDR_W = 10,
    parameter int DMEM_WORDS  = 1024
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   go,
    output logic [IMEM_ADDR_W-1:0] imem_addr,
    input  rv_pkg::word_t          imem_data,
    output rv_pkg::word_t          led_data,
    output logic                   halted,
    output rv_pkg::word_t          cycle_count
);

    localparam rv_pkg::word_t NOP = 32'h0000_0013;  // addi x0, x0, 0

    typedef struct packed {
        rv_pkg::word_t pc;
        rv_pkg::word_t instr;
    } if_id_t;

    typedef struct packed {
        rv_pkg::word_t     pc;
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        rv_pkg::reg_addr_t rd;
        rv_pkg::word_t     rdata1;
        rv_pkg::word_t     rdata2;
        rv_pkg::word_t     imm;
        rv_pkg::alu_op_t   alu_op;
        logic              alu_src;
        logic              mem_read;
        logic              mem_write;
        logic              reg_write;
        logic              branch_eq;
        logic              branch_ne;
        logic              jal;
        logic              jalr;
        logic              ecall;
    } id_ex_t;

    typedef struct packed {
        rv_pkg::word_t     alu_res;
        rv_pkg::word_t     store_data;
        rv_pkg::word_t     pc4;
        rv_pkg::reg_addr_t rd;
        logic              mem_read;
        logic              mem_write;
        logic              reg_write;
        logic              jump;
        logic              halt;
    } ex_mem_t;

    typedef struct packed {
        rv_pkg::word_t     alu_res;
        rv_pkg::word_t     load_data;
        rv_pkg::word_t     pc4;
        rv_pkg::reg_addr_t rd;
        logic              mem_read;
        logic              reg_write;
        logic              jump;
        logic              halt;
    } mem_wb_t;

    rv_pkg::word_t pc;
    if_id_t        if_id;
    id_ex_t        id_ex, id_dec;
    ex_mem_t       ex_mem;
    mem_wb_t       mem_wb;

    logic             advance, load_use, redirect, taken, print;
    logic             uses_rs2, alu_eq;
    rv_pkg::fwd_sel_t fwd_a, fwd_b;
    rv_pkg::word_t    op_a, op_b, alu_b, alu_res, target;
    rv_pkg::word_t    mem_fwd, wb_data, load_data;

    // a halting ecall in write-back freezes everything unless go
    assign halted  = mem_wb.halt && !go;
    assign advance = !halted;

    assign imem_addr = pc[IMEM_ADDR_W+1:2];

    // decode
    decoder decoder_inst (
        .instr     (if_id.instr),
        .alu_op    (id_dec.alu_op),
        .alu_src   (id_dec.alu_src),
        .mem_read  (id_dec.mem_read),
        .mem_write (id_dec.mem_write),
        .reg_write (id_dec.reg_write),
        .branch_eq (id_dec.branch_eq),
        .branch_ne (id_dec.branch_ne),
        .jal       (id_dec.jal),
        .jalr      (id_dec.jalr),
        .ecall     (id_dec.ecall),
        .uses_rs2  (uses_rs2),
        .rs1       (id_dec.rs1),
        .rs2       (id_dec.rs2),
        .rd        (id_dec.rd),
        .imm       (id_dec.imm)
    );
    assign id_dec.pc = if_id.pc;

    regfile regfile_inst (
        .clk    (clk),
        .we     (mem_wb.reg_write && advance),
        .waddr  (mem_wb.rd),
        .wdata  (wb_data),
        .raddr1 (id_dec.rs1),
        .raddr2 (id_dec.rs2),
        .rdata1 (id_dec.rdata1),
        .rdata2 (id_dec.rdata2)
    );

    hazard_unit hazard_unit_inst (
        .id_rs1        (id_dec.rs1),
        .id_rs2        (id_dec.rs2),
        .id_uses_rs2   (uses_rs2),
        .ex_rs1        (id_ex.rs1),
        .ex_rs2        (id_ex.rs2),
        .ex_rd         (id_ex.rd),
        .mem_rd        (ex_mem.rd),
        .wb_rd         (mem_wb.rd),
        .ex_mem_read   (id_ex.mem_read),
        .mem_reg_write (ex_mem.reg_write),
        .wb_reg_write  (mem_wb.reg_write),
        .load_use      (load_use),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    // execute operands
    always_comb begin
        case (fwd_a)
            rv_pkg::FWD_MEM: op_a = mem_fwd;
            rv_pkg::FWD_WB:  op_a = wb_data;
            default:         op_a = id_ex.rdata1;
        endcase
        case (fwd_b)
            rv_pkg::FWD_MEM: op_b = mem_fwd;
            rv_pkg::FWD_WB:  op_b = wb_data;
            default:         op_b = id_ex.rdata2;
        endcase
    end
    assign alu_b = id_ex.alu_src ? id_ex.imm : op_b;

    alu alu_inst (
        .a      (op_a),
        .b      (alu_b),
        .op     (id_ex.alu_op),
        .result (alu_res),
        .eq     (alu_eq)
    );

    assign taken = (id_ex.branch_eq && alu_eq) || (id_ex.branch_ne && !alu_eq);
    assign redirect = taken || id_ex.jal || id_ex.jalr;
    // jalr target is rs1 + imm from the alu, low bit cleared
    assign target = id_ex.jalr ? {alu_res[31:1], 1'b0} : id_ex.pc + id_ex.imm;

    assign print = id_ex.ecall && op_a == rv_pkg::ECALL_PRINT;  // a7 via rs1

    // memory
    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) data_mem_inst (
        .clk   (clk),
        .we    (ex_mem.mem_write && advance),
        .addr  (ex_mem.alu_res),
        .wdata (ex_mem.store_data),
        .rdata (load_data)
    );

    assign mem_fwd = ex_mem.jump ? ex_mem.pc4 : ex_mem.alu_res;

    // write-back select
    assign wb_data = mem_wb.jump     ? mem_wb.pc4 :
                     mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= '0;
            if_id        <= '{pc: '0, instr: NOP};
            id_ex        <= '0;
            ex_mem       <= '0;
            mem_wb       <= '0;
            led_data     <= '0;
            cycle_count  <= '0;
        end else if (advance) begin
            cycle_count <= cycle_count + 1'b1;
            if (print) led_data <= op_b;  // a0 via rs2

            if (redirect) begin
                pc    <= target;
                if_id <= '{pc: '0, instr: NOP};  // squash wrong path
            end else if (!load_use) begin
                pc    <= pc + 32'd4;
                if_id <= '{pc: pc, instr: imem_data};
            end

            // bubble on flush or load-use stall
            id_ex <= (redirect || load_use) ? '0 : id_dec;

            ex_mem.alu_res    <= alu_res;
            ex_mem.store_data <= op_b;
            ex_mem.pc4        <= id_ex.pc + 32'd4;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.jump       <= id_ex.jal || id_ex.jalr;
            ex_mem.halt       <= id_ex.ecall && !print;

            mem_wb.alu_res   <= ex_mem.alu_res;
            mem_wb.load_data <= load_data;
            mem_wb.pc4       <= ex_mem.pc4;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.mem_read  <= ex_mem.mem_read;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.jump      <= ex_mem.jump;
            mem_wb.halt      <= ex_mem.halt;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// instruction store behind the fetch port
rv_pkg::word_t imem [1 << IMEM_ADDR_W];
int            prog_len;

localparam rv_pkg::word_t ECALL = {25'd0, rv_pkg::OPC_SYSTEM};

function automatic rv_pkg::word_t r_type(logic [6:0] f7, logic [2:0] f3, rv_pkg::reg_addr_t rd,
                                         rv_pkg::reg_addr_t rs1, rv_pkg::reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

function automatic rv_pkg::word_t i_type(logic [6:0] opc, logic [2:0] f3, rv_pkg::reg_addr_t rd,
                                         rv_pkg::reg_addr_t rs1, rv_pkg::word_t imm);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

// always sw
function automatic rv_pkg::word_t s_type(rv_pkg::reg_addr_t rs2, rv_pkg::reg_addr_t rs1,
                                         rv_pkg::word_t imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic rv_pkg::word_t b_type(logic [2:0] f3, rv_pkg::reg_addr_t rs1,
                                         rv_pkg::reg_addr_t rs2, rv_pkg::word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic rv_pkg::word_t j_type(rv_pkg::reg_addr_t rd, rv_pkg::word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
endfunction

function automatic rv_pkg::word_t addi(rv_pkg::reg_addr_t rd, rv_pkg::reg_addr_t rs1,
                                       rv_pkg::word_t imm);
    return i_type(rv_pkg::OPC_OP_IMM, 3'b000, rd, rs1, imm);
endfunction

// unused words are nops tagged with their own word address
function automatic void clear_program();
    int i;
    for (i = 0; i < (1 << IMEM_ADDR_W); i++) begin
        imem[i] = addi(5'd0, 5'd0, i);
    end
    prog_len = 0;
endfunction

function automatic void append(rv_pkg::word_t instr);
    imem[prog_len] = instr;
    prog_len++;
endfunction

// show a0 on the leds
function automatic void call_print();
    append(addi(rv_pkg::REG_A7, 5'd0, rv_pkg::ECALL_PRINT));
    append(ECALL);
endfunction

function automatic void call_exit();
    append(addi(rv_pkg::REG_A7, 5'd0, 32'd10));  // any other service halts
    append(ECALL);
endfunction

`endif

// ==== testbench/tb_riscv_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_cpu;

    localparam int IMEM_ADDR_W = 10;
    localparam int TESTS       = 6;
    localparam int TEST_CYCLES = 400;
    localparam int PERIOD_NS   = 4;

    logic                   clk;
    logic                   rst;
    logic                   go;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    rv_pkg::word_t          imem_data;
    rv_pkg::word_t          led_data;
    logic                   halted;
    rv_pkg::word_t          cycle_count;
    rv_pkg::word_t          rng_state;

    `include "tb_programs.svh"

    riscv_cpu #(
        .IMEM_ADDR_W (IMEM_ADDR_W),
        .DMEM_WORDS  (1024)
    ) riscv_cpu_inst (
        .clk         (clk),
        .rst         (rst),
        .go          (go),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .led_data    (led_data),
        .halted      (halted),
        .cycle_count (cycle_count)
    );

    always #2 clk = ~clk;

    always_comb imem_data = imem[imem_addr];  // same-cycle fetch answer

    task automatic abort_run(string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(rv_pkg::word_t actual, rv_pkg::word_t expected, string what);
        if (actual !== expected) begin
            abort_run($sformatf("ERR at %0t ns: %s is %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_bit(logic actual, logic expected, string what);
        if (actual !== expected) begin
            abort_run($sformatf("ERR at %0t ns: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    // xorshift32
    function automatic rv_pkg::word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic rv_pkg::word_t random_imm();
        rv_pkg::word_t r;
        r = next_random();
        return {{20{r[11]}}, r[11:0]};  // fits an I-type immediate
    endfunction

    task automatic reset_dut();
        @(negedge clk);
        rst = 1'b1;
        go  = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_to_halt();
        int n;
        n = 0;
        @(negedge clk);
        while (halted !== 1'b1) begin
            if (n == 300) abort_run("the program never halted");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_for_print(rv_pkg::word_t old);
        int n;
        n = 0;
        @(negedge clk);
        while (led_data === old) begin
            if (n == 300) abort_run("the led output never changed");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic test_reset();
        clear_program();
        call_exit();
        @(negedge clk);
        rst = 1'b1;
        go  = 1'b0;
        repeat (8) @(negedge clk);
        check_bit(halted, 1'b0, "halted during reset");
        check_word(led_data, 32'd0, "led_data during reset");
        check_word(cycle_count, 32'd0, "cycle_count during reset");
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_bit(halted, 1'b0, "halted after reset");
        check_word(led_data, 32'd0, "led_data after reset");
        check_word(cycle_count, 32'd0, "cycle_count after reset");
        run_to_halt();
        check_word(cycle_count, 32'd5, "cycles to a bare exit");  // 2 instrs + 3
        check_word(led_data, 32'd0, "led_data without a print");
    endtask

    task automatic test_forwarding();
        rv_pkg::word_t i1, i2, v5, v6, v7, v8, v28, v29, v30;
        i1 = random_imm();
        i2 = random_imm();
        clear_program();
        append(addi(5, 0, i1));
        append(addi(6, 5, i2));
        append(r_type(7'h00, 3'b000, 7, 6, 5));          // add x7, x6, x5
        append(r_type(7'h20, 3'b000, 8, 7, 6));          // sub x8, x7, x6
        append(r_type(7'h00, 3'b111, 28, 8, 7));         // and
        append(r_type(7'h00, 3'b110, 29, 28, 6));        // or
        append(r_type(7'h00, 3'b010, 30, 29, 7));        // slt
        append(r_type(7'h00, 3'b000, rv_pkg::REG_A0, 30, 29));
        call_print();
        call_exit();
        reset_dut();
        run_to_halt();
        v5  = i1;
        v6  = v5 + i2;
        v7  = v6 + v5;
        v8  = v7 - v6;
        v28 = v8 & v7;
        v29 = v28 | v6;
        v30 = ($signed(v29) < $signed(v7)) ? 32'd1 : 32'd0;
        check_word(led_data, v30 + v29, "forwarding chain result");
        check_word(cycle_count, 32'd15, "cycles without hazards");
    endtask

    task automatic test_load_use();
        rv_pkg::word_t r1, r2;
        r1 = random_imm();
        r2 = random_imm();
        clear_program();
        append(addi(5, 0, r1));
        append(addi(6, 0, r2));
        append(s_type(5, 0, 64));
        append(s_type(6, 0, 68));
        append(i_type(rv_pkg::OPC_LOAD, 3'b010, 7, 0, 64));   // lw x7, 64(x0)
        append(addi(28, 7, 0));                                // stalls once
        append(i_type(rv_pkg::OPC_LOAD, 3'b010, 8, 0, 68));
        append(r_type(7'h00, 3'b000, rv_pkg::REG_A0, 28, 8));  // load used as rs2
        call_print();
        call_exit();
        reset_dut();
        run_to_halt();
        check_word(led_data, r1 + r2, "sum of loaded words");
        check_word(cycle_count, 32'd17, "cycles with two load-use stalls");
    endtask

    task automatic test_branch_loop();
        rv_pkg::word_t n;
        n = next_random() % 32'd20 + 32'd1;
        clear_program();
        append(addi(5, 0, n));                     // counter
        append(addi(6, 0, 0));                     // accumulator
        append(r_type(7'h00, 3'b000, 6, 6, 5));    // loop
        append(addi(5, 5, -1));
        append(b_type(3'b001, 5, 0, -8));          // bne back to loop
        append(b_type(3'b000, 5, 6, 8));           // beq, never taken here
        append(addi(6, 6, 7));
        append(addi(rv_pkg::REG_A0, 6, 0));
        call_print();
        call_exit();
        reset_dut();
        run_to_halt();
        check_word(led_data, n * (n + 1) / 2 + 32'd7, "loop sum");
        // 3n + 9 issued, plus 3, plus 2 per taken bne
        check_word(cycle_count, 5 * n + 32'd10, "cycles of the loop");
    endtask

    task automatic test_jump_link();
        clear_program();
        append(addi(5, 0, 0));
        append(j_type(1, 28));                       // jal x1, to word 8
        append(addi(5, 5, 1));                       // runs once, after return
        append(addi(rv_pkg::REG_A0, 5, 32'h120));    // marker
        call_print();
        call_exit();
        append(addi(rv_pkg::REG_A0, 1, 0));          // subroutine, show the link
        call_print();
        append(i_type(rv_pkg::OPC_JALR, 3'b000, 0, 1, 1));  // odd offset, bit 0 dropped
        reset_dut();
        wait_for_print(32'd0);
        check_word(led_data, 32'd8, "link register");
        run_to_halt();
        check_word(led_data, 32'h121, "marker after return");
        check_word(cycle_count, 32'd19, "cycles with two jumps");
    endtask

    task automatic test_halt_go();
        rv_pkg::word_t v1, v2;
        v1 = random_imm();
        v2 = v1 + (next_random() & 32'h3ff) + 32'd1;
        clear_program();
        append(addi(rv_pkg::REG_A0, 0, v1));
        call_print();
        call_exit();
        append(addi(rv_pkg::REG_A0, rv_pkg::REG_A0, v2 - v1));
        call_print();
        call_exit();
        reset_dut();
        run_to_halt();
        check_word(led_data, v1, "first print");
        check_word(cycle_count, 32'd8, "cycles to first halt");
        repeat (20) begin
            @(negedge clk);
            check_bit(halted, 1'b1, "halted while waiting for go");
            check_word(cycle_count, 32'd8, "cycle_count while halted");
        end
        @(negedge clk);
        go = 1'b1;
        @(negedge clk);
        check_word(cycle_count, 32'd9, "cycle_count after one go step");
        go = 1'b0;
        @(negedge clk);
        check_bit(halted, 1'b0, "halted after the go step");
        run_to_halt();
        check_word(led_data, v2, "second print");
        check_word(cycle_count, 32'd13, "cycles to second halt");
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        go        = 1'b0;
        rng_state = 32'h5a46_1ebd;
        clear_program();
        test_reset();
        test_forwarding();
        test_load_use();
        test_branch_loop();
        test_jump_link();
        test_halt_go();
        $display("test passed");
        $finish;
    end

    // watchdog
    initial begin
        #(TESTS * TEST_CYCLES * PERIOD_NS);
        abort_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+testbench
hw/rv_pkg.sv
hw/regfile.sv
hw/alu.sv
hw/decoder.sv
hw/hazard_unit.sv
hw/data_mem.sv
hw/riscv_cpu.sv
testbench/tb_riscv_cpu.sv
